// ==== verilog/soc_bus_pkg.sv ====
// Load/store bus widths and packed types shared by every bus agent
// Import inside a module body, use scoped names in port lists

package soc_bus_pkg;

  //////////////////////////////
  // Bus widths
  //////////////////////////////

  localparam int unsigned SOC_DAW = 15;         // Byte address width
  localparam int unsigned SOC_DDW = 32;         // Data width
  localparam int unsigned SOC_DBW = SOC_DDW/8;  // Byte enable width

  //////////////////////////////
  // Address word, two views
  //////////////////////////////

  // Memory view of the address
  typedef struct packed {
    logic               rgn;  // Region, 0 for memory
    logic [SOC_DAW-4:0] idx;  // Word index
    logic [1:0]         off;  // Byte offset
  } soc_adr_mem_t;

  // Peripheral view of the address
  typedef struct packed {
    logic               rgn;  // Region, 1 for peripherals
    logic [SOC_DAW-6:0] spr;  // Spare, not decoded
    logic [1:0]         rix;  // Register index
    logic [1:0]         off;  // Byte offset
  } soc_adr_per_t;

  typedef union packed {
    soc_adr_mem_t mem;
    soc_adr_per_t per;
  } soc_adr_u;

  //////////////////////////////
  // Request and response
  //////////////////////////////

  typedef struct packed {
    logic               vld;  // Transfer valid
    logic               wen;  // Write enable
    soc_adr_u           adr;  // Byte address
    logic [SOC_DBW-1:0] ben;  // Byte enables
    logic [SOC_DDW-1:0] wdt;  // Write data
  } soc_req_t;

  typedef struct packed {
    logic [SOC_DDW-1:0] rdt;  // Read data, one cycle after accept
    logic               rdy;  // Ready level
  } soc_rsp_t;

endpackage

// ==== verilog/soc_gpio_pkg.sv ====
// GPIO controller register map
// Register index type and byte offsets inside the peripheral region

package soc_gpio_pkg;

  // Register index from the peripheral address view
  typedef enum logic [1:0] {
    GPIO_OUT = 2'd0,  // Output values
    GPIO_ENA = 2'd1,  // Output enables
    GPIO_IN  = 2'd2   // Synchronized inputs, read only
  } soc_gpio_reg_e;   // Index 3 reserved, reads zero

  //////////////////////////////
  // Byte offsets
  //////////////////////////////

  localparam logic [3:0] GPIO_OUT_OFS = {GPIO_OUT, 2'b00};
  localparam logic [3:0] GPIO_ENA_OFS = {GPIO_ENA, 2'b00};
  localparam logic [3:0] GPIO_IN_OFS  = {GPIO_IN,  2'b00};

endpackage

// ==== verilog/soc_bus_dec.sv ====
// Load/store bus decoder, address top bit picks memory or peripherals
// Read data is steered back by the region remembered at accept time

`timescale 1ns/1ps

module soc_bus_dec (
  // System
  input  logic                  clk,
  input  logic                  rst,
  // Upstream bus
  input  soc_bus_pkg::soc_req_t req,
  output soc_bus_pkg::soc_rsp_t rsp,
  // Memory side
  output soc_bus_pkg::soc_req_t mem_req,
  input  soc_bus_pkg::soc_rsp_t mem_rsp,
  // Peripheral side
  output soc_bus_pkg::soc_req_t per_req,
  input  soc_bus_pkg::soc_rsp_t per_rsp
);

  import soc_bus_pkg::*;

  //////////////////////////////
  // Request routing
  //////////////////////////////

  logic sel;    // Region of current request, 1 is peripherals
  logic rd_acc; // Read accepted this cycle
  logic sel_q;  // Region of the last accepted read

  assign sel = req.adr.mem.rgn;  // Same bit in both views

  always_comb begin
    // All fields go to both sides
    mem_req     = req;
    per_req     = req;
    // Only the selected side sees a valid strobe
    mem_req.vld = req.vld & ~sel;
    per_req.vld = req.vld &  sel;
  end

  //////////////////////////////
  // Response steering
  //////////////////////////////

  assign rd_acc = req.vld & rsp.rdy & ~req.wen;

  // Remember the region until the next read
  always_ff @(posedge clk) begin
    if (rst) begin
      sel_q <= 1'b0;  // Memory
    end else if (rd_acc) begin
      sel_q <= sel;
    end
  end

  always_comb begin
    rsp.rdy = sel   ? per_rsp.rdy : mem_rsp.rdy;  // Follows current request
    rsp.rdt = sel_q ? per_rsp.rdt : mem_rsp.rdt;  // Follows previous read
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Routing depends on a known address
  a_adr_known: assert property (
    @(posedge clk) disable iff (rst)
    req.vld |-> !$isunknown(req.adr)
  );

endmodule

// ==== verilog/soc_mem.sv ====
// Single port data memory on the load/store bus
// Byte writes at the accepting edge, registered reads

`timescale 1ns/1ps

module soc_mem #(
  parameter int unsigned MAW = 12  // Word address width
)(
  input  logic                  clk,
  input  soc_bus_pkg::soc_req_t req,
  output soc_bus_pkg::soc_rsp_t rsp
);

  import soc_bus_pkg::*;

  localparam int unsigned MSZ = 2**MAW;  // Number of words

  logic [SOC_DDW-1:0] mem [0:MSZ-1];
  logic [MAW-1:0]     idx;  // Word index into the array
  logic [SOC_DDW-1:0] rdt;  // Registered read data

  assign idx = req.adr.mem.idx[MAW-1:0];  // Upper index bits alias

  //////////////////////////////
  // Write and read ports
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (req.vld & req.wen) begin
      for (int b = 0; b < SOC_DBW; b++) begin
        if (req.ben[b]) begin
          mem[idx][8*b+:8] <= req.wdt[8*b+:8];  // One byte lane
        end
      end
    end
  end

  // Held between reads
  always_ff @(posedge clk) begin
    if (req.vld & ~req.wen) begin
      rdt <= mem[idx];
    end
  end

  always_comb begin
    rsp.rdt = rdt;
    rsp.rdy = 1'b1;  // Never stalls
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Empty write means a broken store path upstream
  a_wr_ben: assert property (
    @(posedge clk)
    (req.vld && req.wen) |-> (|req.ben)
  );

endmodule

// ==== verilog/soc_gpio.sv ====
// GPIO controller on the peripheral side of the bus
// Output and enable registers plus a synchronized input register

`timescale 1ns/1ps

module soc_gpio #(
  parameter int unsigned GW = 32  // Number of pins, 1 to 32
)(
  // System
  input  logic                  clk,
  input  logic                  rst,
  // Bus
  input  soc_bus_pkg::soc_req_t req,
  output soc_bus_pkg::soc_rsp_t rsp,
  // Pins
  output logic [GW-1:0]         gpio_o,  // Output values
  output logic [GW-1:0]         gpio_e,  // Output enables
  input  logic [GW-1:0]         gpio_i   // Asynchronous inputs
);

  import soc_bus_pkg::*;
  import soc_gpio_pkg::*;

  soc_gpio_reg_e      rix;      // Selected register
  logic               wr;       // Write accepted
  logic               rd;       // Read accepted
  logic [SOC_DDW-1:0] bmask;    // Byte enables spread to bits
  logic [SOC_DDW-1:0] out_nxt;  // Merged output value
  logic [SOC_DDW-1:0] ena_nxt;  // Merged enable value
  logic [SOC_DDW-1:0] rd_val;   // Read mux
  logic [SOC_DDW-1:0] rdt;      // Registered read data
  logic [GW-1:0]      in_s1;    // First synchronizer stage
  logic [GW-1:0]      in_s2;    // GPIO_IN register

  assign rix = soc_gpio_reg_e'(req.adr.per.rix);
  assign wr  = req.vld &  req.wen;
  assign rd  = req.vld & ~req.wen;

  //////////////////////////////
  // Byte merge for writes
  //////////////////////////////

  always_comb begin
    for (int b = 0; b < SOC_DBW; b++) begin
      bmask[8*b+:8] = {8{req.ben[b]}};
    end
  end

  assign out_nxt = (SOC_DDW'(gpio_o) & ~bmask) | (req.wdt & bmask);
  assign ena_nxt = (SOC_DDW'(gpio_e) & ~bmask) | (req.wdt & bmask);

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      gpio_o <= '0;
      gpio_e <= '0;
    end else if (wr) begin
      if (rix == GPIO_OUT) gpio_o <= out_nxt[GW-1:0];
      if (rix == GPIO_ENA) gpio_e <= ena_nxt[GW-1:0];
      // GPIO_IN and index 3 ignore writes
    end
  end

  // Two flop input synchronizer
  always_ff @(posedge clk) begin
    if (rst) begin
      in_s1 <= '0;
      in_s2 <= '0;
    end else begin
      in_s1 <= gpio_i;
      in_s2 <= in_s1;
    end
  end

  //////////////////////////////
  // Read path
  //////////////////////////////

  always_comb begin
    case (rix)
      GPIO_OUT: rd_val = SOC_DDW'(gpio_o);
      GPIO_ENA: rd_val = SOC_DDW'(gpio_e);
      GPIO_IN:  rd_val = SOC_DDW'(in_s2);
      default:  rd_val = '0;  // Reserved
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rdt <= '0;
    end else if (rd) begin
      rdt <= rd_val;  // Held until next read
    end
  end

  always_comb begin
    rsp.rdt = rdt;
    rsp.rdy = 1'b1;
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Pins reach GPIO_IN through two flops and the read register
  a_in_lat: assert property (
    @(posedge clk) disable iff (rst)
    (rd && rix == GPIO_IN) |=> (rsp.rdt[GW-1:0] == $past(gpio_i, 3))
  );

endmodule

// ==== verilog/soc_top.sv ====
// Data side of the SoC, load/store bus in, GPIO pins out
// Decoder splits the bus between data memory and GPIO controller

`timescale 1ns/1ps

module soc_top #(
  parameter int unsigned GW  = 32,  // GPIO width
  parameter int unsigned MAW = 12   // Memory word address width
)(
  // System
  input  logic                  clk,
  input  logic                  rst,
  // Load/store bus
  input  soc_bus_pkg::soc_req_t ls_req,
  output soc_bus_pkg::soc_rsp_t ls_rsp,
  // GPIO pins
  output logic [GW-1:0]         gpio_o,
  output logic [GW-1:0]         gpio_e,
  input  logic [GW-1:0]         gpio_i
);

  import soc_bus_pkg::*;

  soc_req_t mem_req;  // Lower half of address space
  soc_rsp_t mem_rsp;
  soc_req_t per_req;  // Upper half
  soc_rsp_t per_rsp;

  //////////////////////////////
  // Decoder
  //////////////////////////////

  soc_bus_dec ls_dec (
    .clk     (clk),
    .rst     (rst),
    .req     (ls_req),
    .rsp     (ls_rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .per_req (per_req),
    .per_rsp (per_rsp)
  );

  //////////////////////////////
  // Slaves
  //////////////////////////////

  soc_mem #(
    .MAW (MAW)
  ) dmem (
    .clk (clk),
    .req (mem_req),
    .rsp (mem_rsp)
  );

  soc_gpio #(
    .GW (GW)
  ) soc_gpio (
    .clk    (clk),
    .rst    (rst),
    .req    (per_req),
    .rsp    (per_rsp),
    .gpio_o (gpio_o),
    .gpio_e (gpio_e),
    .gpio_i (gpio_i)
  );

endmodule

// ==== verification/soc_tb.sv ====
// Directed testbench for the data side of the SoC
// Drives the load/store bus in place of the core and checks memory and GPIO

`timescale 1ns/1ps

module soc_tb;

  import soc_bus_pkg::*;
  import soc_gpio_pkg::*;

  localparam int GW         = 32;
  localparam int MAW        = 12;
  localparam int CLK_PERIOD = 8;   // ns
  localparam int N_WORDS    = 32;  // Full word writes
  localparam int N_PART     = 16;  // Partial byte writes
  localparam int N_ALT      = 16;  // Alternating reads
  // Reset, then each test in bus cycles
  localparam int TEST_CYCLES = 5 + 2 + 2*N_WORDS + 2*N_PART + 5 + 10 + N_ALT + 1;

  logic          clk;
  logic          rst;
  soc_req_t      ls_req;
  soc_rsp_t      ls_rsp;
  logic [GW-1:0] gpio_o;
  logic [GW-1:0] gpio_e;
  logic [GW-1:0] gpio_i;

  logic [31:0] ref_mem [0:2**MAW-1];  // Memory model
  logic [31:0] ref_out;               // GPIO_OUT model
  logic [31:0] ref_ena;               // GPIO_ENA model
  logic [31:0] ref_in;                // Value on the input pins
  logic [11:0] idx_list [0:N_WORDS-1];
  integer      seed;
  int          errors;

  soc_top #(
    .GW  (GW),
    .MAW (MAW)
  ) soc_top_inst (
    .clk    (clk),
    .rst    (rst),
    .ls_req (ls_req),
    .ls_rsp (ls_rsp),
    .gpio_o (gpio_o),
    .gpio_e (gpio_e),
    .gpio_i (gpio_i)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [14:0] mem_adr(input logic [11:0] idx);
    return {1'b0, idx, 2'b00};  // Region 0, word aligned
  endfunction

  function automatic logic [14:0] gpio_adr(input logic [1:0] rix);
    return {1'b1, 10'd0, rix, 2'b00};  // Region 1
  endfunction

  // Old word with the enabled bytes replaced
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdt,
                                              input logic [3:0] ben);
    logic [31:0] r;
    r = old;
    for (int b = 0; b < 4; b++) begin
      if (ben[b]) r[8*b+:8] = wdt[8*b+:8];
    end
    return r;
  endfunction

  task automatic report_err(input string name, input logic [31:0] exp, input logic [31:0] act);
    errors++;
    $display("ERR %s expected %h actual %h", name, exp, act);
  endtask

  // Leaves vld high, so the caller may chain the next transfer
  task automatic issue(input logic wen, input logic [14:0] adr, input logic [3:0] ben,
                       input logic [31:0] wdt);
    ls_req.vld = 1'b1;
    ls_req.wen = wen;
    ls_req.adr = adr;
    ls_req.ben = ben;
    ls_req.wdt = wdt;
    do @(posedge clk); while (!ls_rsp.rdy);  // Accepting edge
    #1;
  endtask

  task automatic bus_write(input logic [14:0] adr, input logic [3:0] ben, input logic [31:0] wdt);
    issue(1'b1, adr, ben, wdt);
    ls_req.vld = 1'b0;
  endtask

  // Data is registered at the accepting edge
  task automatic bus_read(input logic [14:0] adr, input logic [31:0] exp);
    issue(1'b0, adr, 4'hf, 32'd0);
    ls_req.vld = 1'b0;
    if (ls_rsp.rdt !== exp) report_err("ls_rsp.rdt", exp, ls_rsp.rdt);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic reset_state_test();
    if (gpio_o !== '0) report_err("gpio_o", 32'd0, gpio_o);
    if (gpio_e !== '0) report_err("gpio_e", 32'd0, gpio_e);
    if (ls_rsp.rdy !== 1'b1) report_err("ls_rsp.rdy", 32'd1, {31'd0, ls_rsp.rdy});
    bus_read(gpio_adr(GPIO_OUT), 32'd0);
    bus_read(gpio_adr(GPIO_ENA), 32'd0);
  endtask

  task automatic mem_word_test();
    logic [11:0] base;
    logic [31:0] d;
    base = $random(seed);
    for (int i = 0; i < N_WORDS; i++) begin
      idx_list[i] = 12'(base + i*131);  // Odd stride, all distinct
      d = $random(seed);
      bus_write(mem_adr(idx_list[i]), 4'hf, d);
      ref_mem[idx_list[i]] = d;
    end
    for (int i = 0; i < N_WORDS; i++) begin
      bus_read(mem_adr(idx_list[i]), ref_mem[idx_list[i]]);
    end
  endtask

  task automatic mem_byte_test();
    logic [3:0]  ben;
    logic [31:0] d;
    for (int i = 0; i < N_PART; i++) begin
      ben = $random(seed);
      if (ben == 4'd0) ben = 4'b0001;  // Empty write not legal
      d = $random(seed);
      bus_write(mem_adr(idx_list[i]), ben, d);
      ref_mem[idx_list[i]] = merge_bytes(ref_mem[idx_list[i]], d, ben);
    end
    for (int i = 0; i < N_PART; i++) begin
      bus_read(mem_adr(idx_list[i]), ref_mem[idx_list[i]]);
    end
  endtask

  task automatic gpio_reg_test();
    logic [31:0] d;
    d = $random(seed);
    bus_write(gpio_adr(GPIO_OUT), 4'hf, d);
    ref_out = merge_bytes(ref_out, d, 4'hf);
    if (gpio_o !== ref_out) report_err("gpio_o", ref_out, gpio_o);  // Next cycle
    d = $random(seed);
    bus_write(gpio_adr(GPIO_ENA), 4'b0101, d);
    ref_ena = merge_bytes(ref_ena, d, 4'b0101);
    if (gpio_e !== ref_ena) report_err("gpio_e", ref_ena, gpio_e);
    d = $random(seed);
    bus_write(gpio_adr(GPIO_OUT), 4'b1000, d);  // Top byte only
    ref_out = merge_bytes(ref_out, d, 4'b1000);
    if (gpio_o !== ref_out) report_err("gpio_o", ref_out, gpio_o);
    bus_read(gpio_adr(GPIO_OUT), ref_out);
    bus_read(gpio_adr(GPIO_ENA), ref_ena);
  endtask

  task automatic gpio_input_test();
    ref_in = $random(seed);
    gpio_i = ref_in;
    repeat (3) @(posedge clk);  // Through the synchronizer
    #1;
    bus_read(gpio_adr(GPIO_IN), ref_in);
    // Read only register, write must leave everything alone
    bus_write(gpio_adr(GPIO_IN), 4'hf, ~ref_in);
    if (gpio_o !== ref_out) report_err("gpio_o", ref_out, gpio_o);
    if (gpio_e !== ref_ena) report_err("gpio_e", ref_ena, gpio_e);
    bus_read(gpio_adr(GPIO_OUT), ref_out);
    bus_read(gpio_adr(GPIO_ENA), ref_ena);
    bus_read(gpio_adr(GPIO_IN), ref_in);
    bus_read(gpio_adr(2'd3), 32'd0);  // Reserved
  endtask

  // Reads on consecutive cycles, region flips each time
  // Each result is checked while the next read already sits on the bus
  task automatic alt_read_test();
    logic [14:0] adr;
    logic [31:0] exp;
    logic [31:0] exp_q;  // Due from the read accepted at the last edge
    exp_q = '0;
    for (int i = 0; i <= N_ALT; i++) begin
      if (i < N_ALT) begin
        if (i % 2 == 0) begin
          adr = mem_adr(idx_list[i]);
          exp = ref_mem[idx_list[i]];
        end else begin
          case ((i/2) % 3)
            0: begin
              adr = gpio_adr(GPIO_OUT);
              exp = ref_out;
            end
            1: begin
              adr = gpio_adr(GPIO_ENA);
              exp = ref_ena;
            end
            default: begin
              adr = gpio_adr(GPIO_IN);
              exp = ref_in;
            end
          endcase
        end
        ls_req.vld = 1'b1;
        ls_req.wen = 1'b0;
        ls_req.adr = adr;
        ls_req.ben = 4'hf;
        ls_req.wdt = 32'd0;
      end else begin
        ls_req.vld = 1'b0;
      end
      #1;  // Next request settled in the decoder
      if (i > 0 && ls_rsp.rdt !== exp_q) report_err("ls_rsp.rdt", exp_q, ls_rsp.rdt);
      if (i < N_ALT) begin
        exp_q = exp;
        do @(posedge clk); while (!ls_rsp.rdy);  // Accepting edge
        #1;
      end
    end
  endtask

  //////////////////////////////
  // Sequence and verdict
  //////////////////////////////

  initial begin
    seed    = 32'h94bc_6dcb;
    errors  = 0;
    clk     = 1'b0;
    rst     = 1'b1;
    ls_req  = '0;
    gpio_i  = '0;
    ref_out = '0;
    ref_ena = '0;
    ref_in  = '0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    reset_state_test();
    mem_word_test();
    mem_byte_test();
    gpio_reg_test();
    gpio_input_test();
    alt_read_test();
    $display("Checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((TEST_CYCLES + 200) * CLK_PERIOD);
    errors++;
    $display("Timeout, tests did not finish within %0d cycles", TEST_CYCLES + 200);
    $display("Checks done, %0d errors", errors);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== files.f ====
verilog/soc_bus_pkg.sv
verilog/soc_gpio_pkg.sv
verilog/soc_bus_dec.sv
verilog/soc_mem.sv
verilog/soc_gpio.sv
verilog/soc_top.sv
verification/soc_tb.sv
